// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = dma_target_tb
RTL_TOP   = dma_target
FILELIST  = dma_target.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

# RTL sources only, taken from the file list
RTL_FILES = $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

// File: dma_target.f
verilog/dma_target_pkg.sv
verilog/dma_packet_buffer.sv
verilog/dma_read_fifo.sv
verilog/dma_target_ctrl.sv
verilog/dma_target.sv
tb/dma_target_mem.sv
tb/dma_target_tb.sv

// File: tb/dma_target_mem.sv
module dma_target_mem (
  input  logic                     clk,
  input  dma_target_pkg::bus_req_t bus_req,
  input  logic                     bus_ready,
  output dma_target_pkg::data_t    bus_rdata
);
  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Only written words are held here
  // Any other address reads back as the preload pattern
  dma_target_pkg::data_t words [dma_target_pkg::addr_t];

  // Completed transfers, read by the testbench
  int write_count = 0;
  int read_count = 0;

  // Preload value, depends on every address bit
  function automatic dma_target_pkg::data_t preload(dma_target_pkg::addr_t a);
    return a ^ 32'h5a5a0000;
  endfunction

  //////////////////////////////
  // Bus slave
  //////////////////////////////

  // Read data valid in the cycle of the request
  always_comb begin
    if (words.exists(bus_req.addr)) begin
      bus_rdata = words[bus_req.addr];
    end else begin
      bus_rdata = preload(bus_req.addr);
    end
  end

  // Wait states come from bus_ready, driven by the testbench
  // A transfer completes where sel and ready are both high
  always @(posedge clk) begin
    if (bus_req.sel && bus_ready) begin
      if (bus_req.write) begin
        words[bus_req.addr] = bus_req.wdata;
        write_count = write_count + 1;
      end else begin
        read_count = read_count + 1;
      end
    end
  end

endmodule

// File: tb/dma_target_tb.sv
module dma_target_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int packet_size = 16;
  localparam int max_payload = packet_size - 2;
  localparam dma_target_pkg::tile_id_t dut_tile = 5'd3;
  // Tile that sends all requests
  localparam dma_target_pkg::tile_id_t req_tile = 5'd9;

  // Cycle limits per wait, summed for the watchdog
  localparam int write_limit = 200;
  localparam int read_limit = 300;
  localparam int long_limit = 900;
  localparam int test_cycles = 10 + 2 * write_limit + 20 + 2 * read_limit + long_limit;
  localparam int margin = 3;

  logic                     clk;
  logic                     rst;
  dma_target_pkg::flit_t    noc_in_flit;
  logic                     noc_in_valid;
  logic                     noc_in_ready;
  dma_target_pkg::flit_t    noc_out_flit;
  logic                     noc_out_valid;
  logic                     noc_out_ready;
  dma_target_pkg::bus_req_t bus_req;
  dma_target_pkg::data_t    bus_rdata;
  logic                     bus_ready;

  logic [15:0]              lfsr;
  logic                     stalls;
  logic                     req_started;
  int                       errors;
  int                       start_errors;
  int                       tests_run;
  int                       tests_failed;
  string                    test_name;
  dma_target_pkg::flit_t    out_q [$];
  dma_target_pkg::data_t    wdata_q [$];

  dma_target #(
    .packet_size(packet_size),
    .tile_id    (dut_tile)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .noc_in_flit  (noc_in_flit),
    .noc_in_valid (noc_in_valid),
    .noc_in_ready (noc_in_ready),
    .noc_out_flit (noc_out_flit),
    .noc_out_valid(noc_out_valid),
    .noc_out_ready(noc_out_ready),
    .bus_req      (bus_req),
    .bus_rdata    (bus_rdata),
    .bus_ready    (bus_ready)
  );

  dma_target_mem i_mem (
    .clk      (clk),
    .bus_req  (bus_req),
    .bus_ready(bus_ready),
    .bus_rdata(bus_rdata)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // Random ready and capture
  //////////////////////////////

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic random_bit();
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    return lfsr[0];
  endfunction

  always @(negedge clk) begin
    if (stalls) begin
      noc_out_ready = random_bit();
      bus_ready = random_bit();
    end else begin
      noc_out_ready = 1'b1;
      bus_ready = 1'b1;
    end
  end

  // Every response flit that completes a handshake
  always @(posedge clk) begin
    if (!rst && noc_out_valid && noc_out_ready) begin
      out_q.push_back(noc_out_flit);
    end
  end

  task automatic note_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  //////////////////////////////
  // Protocol assertions
  //////////////////////////////

  // Quiet until the first request flit
  assert property (@(posedge clk) disable iff (rst)
    !req_started |-> !noc_out_valid && !bus_req.sel)
  else begin
    note_error("output valid or bus select raised before any request");
  end

  // Stalled response flit holds
  assert property (@(posedge clk) disable iff (rst)
    noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out_flit))
  else begin
    note_error("response flit changed or dropped while noc_out_ready was low");
  end

  // Stalled bus request holds
  assert property (@(posedge clk) disable iff (rst)
    bus_req.sel && !bus_ready |=> $stable(bus_req))
  else begin
    note_error("bus request changed while bus_ready was low");
  end

  task automatic check_value(input string what, input logic [33:0] exp, input logic [33:0] act);
    assert (act == exp)
    else begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    start_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == start_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - start_errors);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  function automatic dma_target_pkg::data_t make_hdr(
    input dma_target_pkg::tile_id_t     dest,
    input dma_target_pkg::packet_id_t   id,
    input dma_target_pkg::tile_id_t     source,
    input dma_target_pkg::packet_type_e ptype,
    input logic                         last,
    input dma_target_pkg::word_count_t  size
  );
    dma_target_pkg::hdr_t h;
    h.dest      = dest;
    h.pclass    = dma_target_pkg::class_dma;
    h.packet_id = id;
    h.source    = source;
    h.ptype     = ptype;
    h.last      = last;
    h.size      = size;
    return h;
  endfunction

  // Called on a falling edge, returns on a falling edge
  task automatic send_flit(input dma_target_pkg::flit_type_e t, input dma_target_pkg::data_t c);
    req_started = 1'b1;
    noc_in_flit.ftype = t;
    noc_in_flit.content = c;
    noc_in_valid = 1'b1;
    @(posedge clk);
    while (!noc_in_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
    noc_in_valid = 1'b0;
  endtask

  task automatic send_write(input dma_target_pkg::addr_t a, input logic last,
                            input dma_target_pkg::packet_id_t id);
    send_flit(dma_target_pkg::flit_header,
              make_hdr(dut_tile, id, req_tile, dma_target_pkg::pkt_l2r_req, last,
                       dma_target_pkg::word_count_t'(wdata_q.size())));
    send_flit(dma_target_pkg::flit_payload, a);
    for (int i = 0; i < wdata_q.size(); i++) begin
      if (i == wdata_q.size() - 1) begin
        send_flit(dma_target_pkg::flit_last, wdata_q[i]);
      end else begin
        send_flit(dma_target_pkg::flit_payload, wdata_q[i]);
      end
    end
  endtask

  // Header, local address, remote address
  task automatic send_read(input dma_target_pkg::addr_t laddr, input dma_target_pkg::addr_t raddr,
                           input int count, input dma_target_pkg::packet_id_t id);
    send_flit(dma_target_pkg::flit_header,
              make_hdr(dut_tile, id, req_tile, dma_target_pkg::pkt_r2l_req, 1'b1,
                       dma_target_pkg::word_count_t'(count)));
    send_flit(dma_target_pkg::flit_payload, laddr);
    send_flit(dma_target_pkg::flit_last, raddr);
  endtask

  //////////////////////////////
  // Waits and checks
  //////////////////////////////

  task automatic wait_for_flits(input int n, input int limit, output bit ok);
    int waited;
    waited = 0;
    while (out_q.size() < n && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    ok = (out_q.size() >= n);
    if (!ok) begin
      note_error($sformatf("timeout in %s: %0d of %0d response flits arrived",
                           test_name, out_q.size(), n));
    end
  endtask

  task automatic wait_for_writes(input int target, input int limit);
    int waited;
    waited = 0;
    while (i_mem.write_count < target && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (i_mem.write_count < target) begin
      note_error($sformatf("timeout in %s: bus writes did not complete", test_name));
    end
  endtask

  // Sent words land at consecutive word addresses
  task automatic check_written(input dma_target_pkg::addr_t a);
    dma_target_pkg::addr_t wa;
    for (int i = 0; i < wdata_q.size(); i++) begin
      wa = a + dma_target_pkg::addr_t'(4 * i);
      if (!i_mem.words.exists(wa)) begin
        note_error($sformatf("%s: memory word at %h was never written", test_name, wa));
      end else begin
        check_value($sformatf("mem %h", wa), 34'(wdata_q[i]), 34'(i_mem.words[wa]));
      end
    end
  endtask

  // Packets of up to max_payload words, expected from the request alone
  task automatic check_read(input dma_target_pkg::addr_t laddr, input dma_target_pkg::addr_t raddr,
                            input int count, input dma_target_pkg::packet_id_t id,
                            input int limit);
    int                    sent;
    int                    n;
    int                    packets;
    int                    reads_start;
    bit                    ok;
    logic                  last;
    dma_target_pkg::flit_t f;
    dma_target_pkg::flit_t exp;
    reads_start = i_mem.read_count;
    packets = (count + max_payload - 1) / max_payload;
    wait_for_flits(count + 2 * packets, limit, ok);
    if (!ok) begin
      return;
    end
    sent = 0;
    while (sent < count) begin
      n = (count - sent > max_payload) ? max_payload : count - sent;
      last = (sent + n == count);
      f = out_q.pop_front();
      exp.ftype = dma_target_pkg::flit_header;
      exp.content = make_hdr(req_tile, id, dut_tile, dma_target_pkg::pkt_r2l_resp, last,
                             dma_target_pkg::word_count_t'(n));
      check_value($sformatf("header at word %0d", sent), exp, f);
      f = out_q.pop_front();
      exp.ftype = dma_target_pkg::flit_payload;
      exp.content = raddr + dma_target_pkg::addr_t'(4 * sent);
      check_value($sformatf("address at word %0d", sent), exp, f);
      for (int i = 0; i < n; i++) begin
        f = out_q.pop_front();
        if (i == n - 1) begin
          exp.ftype = dma_target_pkg::flit_last;
        end else begin
          exp.ftype = dma_target_pkg::flit_payload;
        end
        exp.content = (laddr + dma_target_pkg::addr_t'(4 * (sent + i))) ^ 32'h5a5a0000;
        check_value($sformatf("word %0d", sent + i), exp, f);
      end
      sent += n;
    end
    // One bus read per requested word, none beyond
    check_value("bus reads", 34'(count), 34'(i_mem.read_count - reads_start));
    check_value("extra flits", '0, 34'(out_q.size()));
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    bit                    ok;
    dma_target_pkg::flit_t f;
    dma_target_pkg::hdr_t  h;
    clk = 1'b0;
    rst = 1'b1;
    noc_in_flit = '0;
    noc_in_valid = 1'b0;
    noc_out_ready = 1'b1;
    bus_ready = 1'b1;
    lfsr = 16'd61;
    stalls = 1'b0;
    req_started = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle outputs, also watched by the first property
    begin_test("reset_idle");
    repeat (10) @(negedge clk);
    check_value("out valid", '0, 34'(noc_out_valid));
    check_value("bus sel", '0, 34'(bus_req.sel));
    // Empty buffer takes flits
    check_value("in ready", 34'(1'b1), 34'(noc_in_ready));
    end_test();

    begin_test("l2r_no_resp");
    wdata_q = {32'hc0de0001, 32'h13572468, 32'hffff0000, 32'h0000ffff, 32'ha5a5a5a5};
    send_write(32'h0000_1000, 1'b0, 6'd5);
    wait_for_writes(5, write_limit);
    // Room for a wrong response to show up
    repeat (20) @(negedge clk);
    check_value("flit count", '0, 34'(out_q.size()));
    check_written(32'h0000_1000);
    end_test();

    begin_test("l2r_resp");
    wdata_q = {32'h0badf00d, 32'h76543210};
    send_write(32'h0000_2040, 1'b1, 6'd17);
    wait_for_flits(1, write_limit, ok);
    if (ok) begin
      f = out_q.pop_front();
      h = dma_target_pkg::hdr_t'(f.content);
      check_value("flit type", 34'(dma_target_pkg::flit_single), 34'(f.ftype));
      check_value("dest", 34'(req_tile), 34'(h.dest));
      check_value("source", 34'(dut_tile), 34'(h.source));
      check_value("packet type", 34'(dma_target_pkg::pkt_l2r_resp), 34'(h.ptype));
      check_value("packet id", 34'(6'd17), 34'(h.packet_id));
      check_value("class", 34'(dma_target_pkg::class_dma), 34'(h.pclass));
      check_value("extra flits", '0, 34'(out_q.size()));
    end
    check_written(32'h0000_2040);
    end_test();

    begin_test("r2l_single");
    send_read(32'h0000_4000, 32'h8000_0100, 6, 6'd33);
    check_read(32'h0000_4000, 32'h8000_0100, 6, 6'd33, read_limit);
    end_test();

    // Three packets under random stalls on both sides
    begin_test("r2l_split");
    stalls = 1'b1;
    send_read(32'h5000_0040, 32'h9000_0000, 30, 6'd41);
    check_read(32'h5000_0040, 32'h9000_0000, 30, 6'd41, long_limit);
    stalls = 1'b0;
    end_test();

    begin_test("stray_payload");
    send_flit(dma_target_pkg::flit_payload, 32'hdeadbeef);
    send_read(32'h0000_6000, 32'ha000_0000, 4, 6'd50);
    check_read(32'h0000_6000, 32'ha000_0000, 4, 6'd50, read_limit);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(test_cycles * margin * 20);
    $display("watchdog expired after %0d cycles, simulation stopped", test_cycles * margin);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: verilog/dma_packet_buffer.sv
module dma_packet_buffer #(
  parameter int packet_size = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_target_pkg::flit_t in_flit,
  input  logic                  in_valid,
  output logic                  in_ready,
  output dma_target_pkg::flit_t out_flit,
  output logic                  out_valid,
  input  logic                  out_ready
);

  localparam int ptr_w = (packet_size > 1) ? $clog2(packet_size) : 1;
  localparam int cnt_w = $clog2(packet_size + 1);

  // Flit store, one slot per flit of the longest packet
  dma_target_pkg::flit_t mem [packet_size];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] fill;
  logic [cnt_w-1:0] pkt_count;
  logic             wr_en;
  logic             rd_en;
  logic             wr_end;
  logic             rd_end;

  // Pointer advance, wraps for any depth
  function automatic logic [ptr_w-1:0] ptr_inc(logic [ptr_w-1:0] p);
    if (p == ptr_w'(packet_size - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign in_ready  = (fill != cnt_w'(packet_size));
  // Nothing leaves before a complete packet is held
  assign out_valid = (fill != '0) && (pkt_count != '0);
  assign out_flit  = mem[rd_ptr];

  assign wr_en  = in_valid & in_ready;
  assign rd_en  = out_valid & out_ready;
  assign wr_end = wr_en & dma_target_pkg::flit_is_end(in_flit);
  assign rd_end = rd_en & dma_target_pkg::flit_is_end(out_flit);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  //////////////////////////////
  // Pointers and counters
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      pkt_count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (wr_en && !rd_en) begin
        fill <= fill + 1'b1;
      end else if (!wr_en && rd_en) begin
        fill <= fill - 1'b1;
      end
      // Complete packets held
      if (wr_end && !rd_end) begin
        pkt_count <= pkt_count + 1'b1;
      end else if (!wr_end && rd_end) begin
        pkt_count <= pkt_count - 1'b1;
      end
    end
  end

endmodule

// File: verilog/dma_read_fifo.sv
module dma_read_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  dma_target_pkg::data_t din,
  input  logic                  pop,
  output dma_target_pkg::data_t dout,
  output logic                  not_empty,
  output logic                  not_full
);

  // Three words, head always in entry 0
  dma_target_pkg::data_t data [3];

  // One-hot write slot, bit 3 marks full
  logic [3:0] pos;

  assign dout      = data[0];
  assign not_empty = ~pos[0];
  assign not_full  = ~pos[3];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push && !pop) begin
      pos <= pos << 1;
    end else if (!push && pop) begin
      pos <= pos >> 1;
    end
  end

  //////////////////////////////
  // Shift and write
  //////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (pop) begin
        // Word goes one slot below the current write slot
        if (push && pos[i+1]) begin
          data[i] <= din;
        end else if (i < 2) begin
          data[i] <= data[i+1];
        end
      end else if (push && pos[i]) begin
        data[i] <= din;
      end
    end
  end

endmodule

// File: verilog/dma_target.sv
module dma_target #(
  parameter int                       packet_size = 16,
  parameter dma_target_pkg::tile_id_t tile_id     = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  // NoC input
  input  dma_target_pkg::flit_t    noc_in_flit,
  input  logic                     noc_in_valid,
  output logic                     noc_in_ready,
  // NoC output
  output dma_target_pkg::flit_t    noc_out_flit,
  output logic                     noc_out_valid,
  input  logic                     noc_out_ready,
  // Bus
  output dma_target_pkg::bus_req_t bus_req,
  input  dma_target_pkg::data_t    bus_rdata,
  input  logic                     bus_ready
);

  // Buffer to controller
  dma_target_pkg::flit_t buf_flit;
  logic                  buf_valid;
  logic                  buf_ready;

  // Controller to read FIFO
  logic                  fifo_push;
  logic                  fifo_pop;
  dma_target_pkg::data_t fifo_dout;
  logic                  fifo_not_empty;
  logic                  fifo_not_full;

  // Holds flits until a whole packet is in
  dma_packet_buffer #(
    .packet_size(packet_size)
  ) i_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_flit  (noc_in_flit),
    .in_valid (noc_in_valid),
    .in_ready (noc_in_ready),
    .out_flit (buf_flit),
    .out_valid(buf_valid),
    .out_ready(buf_ready)
  );

  dma_target_ctrl #(
    .packet_size(packet_size),
    .tile_id    (tile_id)
  ) i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .buf_flit      (buf_flit),
    .buf_valid     (buf_valid),
    .buf_ready     (buf_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .bus_req       (bus_req),
    .bus_ready     (bus_ready),
    .fifo_push     (fifo_push),
    .fifo_pop      (fifo_pop),
    .fifo_dout     (fifo_dout),
    .fifo_not_empty(fifo_not_empty),
    .fifo_not_full (fifo_not_full)
  );

  // Read data straight from the bus
  dma_read_fifo i_read_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (fifo_push),
    .din      (bus_rdata),
    .pop      (fifo_pop),
    .dout     (fifo_dout),
    .not_empty(fifo_not_empty),
    .not_full (fifo_not_full)
  );

endmodule

// File: verilog/dma_target_ctrl.sv
module dma_target_ctrl #(
  parameter int                       packet_size = 16,
  parameter dma_target_pkg::tile_id_t tile_id     = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  // Request flits from the packet buffer
  input  dma_target_pkg::flit_t    buf_flit,
  input  logic                     buf_valid,
  output logic                     buf_ready,
  // Response flits
  output dma_target_pkg::flit_t    noc_out_flit,
  output logic                     noc_out_valid,
  input  logic                     noc_out_ready,
  // Bus
  output dma_target_pkg::bus_req_t bus_req,
  input  logic                     bus_ready,
  // Read FIFO
  output logic                     fifo_push,
  output logic                     fifo_pop,
  input  dma_target_pkg::data_t    fifo_dout,
  input  logic                     fifo_not_empty,
  input  logic                     fifo_not_full
);

  // Header and address flit take two of each packet
  localparam dma_target_pkg::word_count_t max_payload =
    dma_target_pkg::word_count_t'(packet_size - 2);

  dma_target_pkg::ctrl_state_e state;
  dma_target_pkg::ctrl_state_e state_nxt;

  // Incoming header and stored request fields
  dma_target_pkg::hdr_t        buf_hdr;
  dma_target_pkg::tile_id_t    req_src;
  dma_target_pkg::packet_id_t  req_id;
  logic                        req_last;
  dma_target_pkg::word_count_t req_size;

  // Local bus address, advanced per transfer
  dma_target_pkg::addr_t       laddr;
  dma_target_pkg::addr_t       raddr;

  // Word and flit counters
  dma_target_pkg::word_count_t words_read;
  dma_target_pkg::word_count_t words_sent;
  dma_target_pkg::word_count_t words_left;
  dma_target_pkg::word_count_t pkt_words;
  dma_target_pkg::word_count_t pkt_words_nxt;
  dma_target_pkg::word_count_t pkt_cnt;

  logic                        final_pkt;
  logic                        final_flit;
  logic                        reading;
  logic                        buf_hs;
  logic                        out_hs;
  dma_target_pkg::hdr_t        resp_hdr;

  assign buf_hdr = dma_target_pkg::hdr_t'(buf_flit.content);
  assign buf_hs  = buf_valid & buf_ready;
  assign out_hs  = noc_out_valid & noc_out_ready;

  //////////////////////////////
  // Packet split
  //////////////////////////////

  // Words_sent only moves at packet end, so these hold over a packet
  assign words_left    = req_size - words_sent;
  assign final_pkt     = (words_left <= max_payload);
  assign pkt_words_nxt = final_pkt ? words_left : max_payload;
  assign final_flit    = (pkt_cnt == pkt_words - 1'b1);

  // Bus reads run beside header and address flits
  assign reading = ((state == dma_target_pkg::r2l_hdr) ||
                    (state == dma_target_pkg::r2l_addr) ||
                    (state == dma_target_pkg::r2l_data)) &&
                   (words_read != req_size) && fifo_not_full;
  assign fifo_push = reading & bus_ready;

  // Response header, shared by both response types
  always_comb begin
    resp_hdr.dest      = req_src;
    resp_hdr.pclass    = dma_target_pkg::class_dma;
    resp_hdr.packet_id = req_id;
    resp_hdr.source    = tile_id;
    if (state == dma_target_pkg::l2r_resp) begin
      resp_hdr.ptype = dma_target_pkg::pkt_l2r_resp;
      resp_hdr.last  = 1'b1;
      resp_hdr.size  = '0;
    end else begin
      resp_hdr.ptype = dma_target_pkg::pkt_r2l_resp;
      resp_hdr.last  = final_pkt;
      resp_hdr.size  = pkt_words_nxt;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_nxt            = state;
    buf_ready            = 1'b0;
    noc_out_valid        = 1'b0;
    noc_out_flit.ftype   = dma_target_pkg::flit_payload;
    noc_out_flit.content = '0;
    fifo_pop             = 1'b0;
    bus_req.sel          = reading;
    bus_req.write        = 1'b0;
    bus_req.addr         = laddr;
    bus_req.wdata        = buf_flit.content;
    case (state)
      dma_target_pkg::idle: begin
        // Anything but a known request header is dropped
        buf_ready = 1'b1;
        if (buf_valid && buf_flit.ftype == dma_target_pkg::flit_header) begin
          if (buf_hdr.ptype == dma_target_pkg::pkt_l2r_req) begin
            state_nxt = dma_target_pkg::l2r_addr;
          end else if (buf_hdr.ptype == dma_target_pkg::pkt_r2l_req) begin
            state_nxt = dma_target_pkg::r2l_laddr;
          end
        end
      end
      dma_target_pkg::l2r_addr: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          // Request without data words
          if (dma_target_pkg::flit_is_end(buf_flit)) begin
            state_nxt = req_last ? dma_target_pkg::l2r_resp : dma_target_pkg::idle;
          end else begin
            state_nxt = dma_target_pkg::l2r_data;
          end
        end
      end
      dma_target_pkg::l2r_data: begin
        // One write per payload flit, flit taken as the bus completes
        bus_req.sel   = buf_valid;
        bus_req.write = 1'b1;
        buf_ready     = bus_ready;
        if (buf_hs && dma_target_pkg::flit_is_end(buf_flit)) begin
          state_nxt = req_last ? dma_target_pkg::l2r_resp : dma_target_pkg::idle;
        end
      end
      dma_target_pkg::l2r_resp: begin
        noc_out_valid        = 1'b1;
        noc_out_flit.ftype   = dma_target_pkg::flit_single;
        noc_out_flit.content = resp_hdr;
        if (noc_out_ready) begin
          state_nxt = dma_target_pkg::idle;
        end
      end
      dma_target_pkg::r2l_laddr: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          state_nxt = dma_target_pkg::r2l_raddr;
        end
      end
      dma_target_pkg::r2l_raddr: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          state_nxt = dma_target_pkg::r2l_hdr;
        end
      end
      dma_target_pkg::r2l_hdr: begin
        noc_out_valid        = 1'b1;
        noc_out_flit.ftype   = dma_target_pkg::flit_header;
        noc_out_flit.content = resp_hdr;
        if (noc_out_ready) begin
          state_nxt = dma_target_pkg::r2l_addr;
        end
      end
      dma_target_pkg::r2l_addr: begin
        // Remote address of this packet's first word
        noc_out_valid        = 1'b1;
        noc_out_flit.content = raddr + (dma_target_pkg::addr_t'(words_sent) << 2);
        if (noc_out_ready) begin
          state_nxt = dma_target_pkg::r2l_data;
        end
      end
      dma_target_pkg::r2l_data: begin
        noc_out_valid        = fifo_not_empty;
        noc_out_flit.content = fifo_dout;
        if (final_flit) begin
          noc_out_flit.ftype = dma_target_pkg::flit_last;
        end
        fifo_pop = fifo_not_empty & noc_out_ready;
        if (fifo_pop && final_flit) begin
          state_nxt = final_pkt ? dma_target_pkg::idle : dma_target_pkg::r2l_hdr;
        end
      end
      default: begin
        state_nxt = dma_target_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= dma_target_pkg::idle;
      words_read <= '0;
      words_sent <= '0;
      pkt_words  <= '0;
      pkt_cnt    <= '0;
    end else begin
      state <= state_nxt;
      // New read request starts both counts from zero
      if (state == dma_target_pkg::r2l_raddr && buf_hs) begin
        words_read <= '0;
        words_sent <= '0;
      end
      if (fifo_push) begin
        words_read <= words_read + 1'b1;
      end
      if (state == dma_target_pkg::r2l_hdr && out_hs) begin
        pkt_words <= pkt_words_nxt;
        pkt_cnt   <= '0;
      end
      if (state == dma_target_pkg::r2l_data && out_hs) begin
        if (final_flit) begin
          words_sent <= words_sent + pkt_words;
        end else begin
          pkt_cnt <= pkt_cnt + 1'b1;
        end
      end
    end
  end

  // Request fields and addresses
  always_ff @(posedge clk) begin
    if (state == dma_target_pkg::idle && buf_hs) begin
      req_src  <= buf_hdr.source;
      req_id   <= buf_hdr.packet_id;
      req_last <= buf_hdr.last;
      req_size <= buf_hdr.size;
    end
    if ((state == dma_target_pkg::l2r_addr || state == dma_target_pkg::r2l_laddr) &&
        buf_hs) begin
      laddr <= buf_flit.content;
    end else if ((state == dma_target_pkg::l2r_data && buf_hs) || fifo_push) begin
      laddr <= laddr + 32'd4;
    end
    if (state == dma_target_pkg::r2l_raddr && buf_hs) begin
      raddr <= buf_flit.content;
    end
  end

endmodule

// File: verilog/dma_target_pkg.sv
package dma_target_pkg;

  //////////////////////////////
  // Bus and count widths
  //////////////////////////////

  // Byte address on the bus
  typedef logic [31:0] addr_t;

  // Data word, same width on the bus and in a flit
  typedef logic [31:0] data_t;

  // Words in a whole request or in one packet
  typedef logic [9:0] word_count_t;

  // NoC identifiers
  typedef logic [4:0] tile_id_t;
  typedef logic [5:0] packet_id_t;

  //////////////////////////////
  // Flit format
  //////////////////////////////

  typedef enum logic [1:0] {
    flit_payload = 2'b00,
    flit_header  = 2'b01,
    flit_last    = 2'b10,
    flit_single  = 2'b11
  } flit_type_e;

  // Two type bits on top of one content word
  typedef struct packed {
    flit_type_e ftype;
    data_t      content;
  } flit_t;

  typedef enum logic [1:0] {
    pkt_l2r_req  = 2'b00,
    pkt_r2l_req  = 2'b01,
    pkt_l2r_resp = 2'b10,
    pkt_r2l_resp = 2'b11
  } packet_type_e;

  // Class of all DMA traffic
  localparam logic [2:0] class_dma = 3'b010;

  // Header flit content, msb first
  typedef struct packed {
    tile_id_t     dest;
    logic [2:0]   pclass;
    packet_id_t   packet_id;
    tile_id_t     source;
    packet_type_e ptype;
    logic         last;
    word_count_t  size;
  } hdr_t;

  //////////////////////////////
  // Bus and controller
  //////////////////////////////

  // Single phase request, completed by bus_ready
  typedef struct packed {
    logic  sel;
    logic  write;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef enum logic [3:0] {
    idle,
    l2r_addr,
    l2r_data,
    l2r_resp,
    r2l_laddr,
    r2l_raddr,
    r2l_hdr,
    r2l_addr,
    r2l_data
  } ctrl_state_e;

  // True for the final flit of a packet
  function automatic logic flit_is_end(flit_t f);
    return (f.ftype == flit_last) || (f.ftype == flit_single);
  endfunction

endpackage
